//--- source/conv_agu_pkg.sv
package conv_agu_pkg;

    // Widths that carry a meaning
    typedef logic [11:0] addr_t;    // Feature-map word address, wraps at 4096
    typedef logic [7:0]  cnt_t;     // Loop counts and loop limits
    typedef logic [3:0]  part_t;    // Part index
    typedef logic [3:0]  ker_t;     // Kernel size and kernel row/column
    typedef logic [1:0]  stride_t;  // Convolution stride

    // FIFO word, MSB first
    // {first_part, last_part, ker_col[3:0], input_col[11:0], base_addr[11:0]}
    typedef logic [29:0] entry_t;

    typedef enum logic [1:0] {
        KER_IDLE,       // Wait for a settled kernel-row address
        KER_COL_EN,     // One kernel column per cycle
        KER_ROW_INC     // Bubble between kernel rows
    } ker_state_e;

    localparam int PE_COLS    = 7;  // PE columns covered by one part
    localparam int PIPE_DEPTH = 3;  // Loop strobe to settled kernel-row address

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_AFULL = FIFO_DEPTH - 2;  // Leaves room for the write in flight

    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [FIFO_AW:0]   fifo_cnt_t;

endpackage

//--- source/conv_agu_cfg.sv
module conv_agu_cfg (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start_req,
    input  conv_agu_pkg::addr_t     i_start_addr,
    input  conv_agu_pkg::cnt_t      i_in_piece_num,
    input  conv_agu_pkg::cnt_t      i_out_piece_num,
    input  conv_agu_pkg::cnt_t      i_out_y_len,
    input  conv_agu_pkg::cnt_t      i_part_num,
    input  conv_agu_pkg::cnt_t      i_in_x_len,
    input  conv_agu_pkg::stride_t   i_stride,
    input  conv_agu_pkg::ker_t      i_kernel,
    input  logic                    i_job_done,
    input  logic                    i_fifo_empty,
    output logic                    o_start_ack,
    output logic                    o_start,
    output conv_agu_pkg::cnt_t      o_in_piece_num,
    output conv_agu_pkg::cnt_t      o_out_piece_num,
    output conv_agu_pkg::cnt_t      o_out_y_len,
    output conv_agu_pkg::cnt_t      o_part_num,
    output conv_agu_pkg::cnt_t      o_in_x_len,
    output conv_agu_pkg::ker_t      o_kernel,
    output conv_agu_pkg::addr_t     o_start_addr,
    output conv_agu_pkg::addr_t     o_one_line_size,
    output conv_agu_pkg::addr_t     o_stride_line_size,
    output conv_agu_pkg::addr_t     o_part_stride
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for req
        ST_BUSY,    // Job running
        ST_ACK      // Ack high until req drops
    } cfg_state_e;

    cfg_state_e          state;
    logic                capture;
    conv_agu_pkg::addr_t line_prod;     // One input line modulo 4096

    assign capture     = (state == ST_IDLE) && i_start_req;
    assign line_prod   = i_in_x_len * i_in_piece_num;
    assign o_start_ack = (state == ST_ACK);

    // ------------------------------------------------------------------------
    // Four-phase job handshake
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            o_start <= 1'b0;
        end else begin
            o_start <= capture;     // One-cycle strobe after capture
            case (state)
                ST_IDLE: if (i_start_req) state <= ST_BUSY;
                // Done flag is stale while start is still high
                ST_BUSY: if (!o_start && i_job_done && i_fifo_empty) state <= ST_ACK;
                ST_ACK:  if (!i_start_req) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Job parameters and derived sizes taken once per job
    always_ff @(posedge i_clk) begin
        if (capture) begin
            o_start_addr       <= i_start_addr;
            o_in_piece_num     <= i_in_piece_num;
            o_out_piece_num    <= i_out_piece_num;
            o_out_y_len        <= i_out_y_len;
            o_part_num         <= i_part_num;
            o_in_x_len         <= i_in_x_len;
            o_kernel           <= i_kernel;
            o_one_line_size    <= line_prod;
            o_stride_line_size <= line_prod * conv_agu_pkg::addr_t'(i_stride);
            o_part_stride      <= conv_agu_pkg::addr_t'(conv_agu_pkg::PE_COLS)
                                  * conv_agu_pkg::addr_t'(i_stride);
        end
    end

endmodule

//--- source/conv_agu_loop_ctrl.sv
module conv_agu_loop_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  conv_agu_pkg::cnt_t  i_in_piece_num,
    input  conv_agu_pkg::cnt_t  i_out_piece_num,
    input  conv_agu_pkg::cnt_t  i_out_y_len,
    input  conv_agu_pkg::cnt_t  i_part_num,
    input  conv_agu_pkg::ker_t  i_kernel,
    input  logic                i_addr_ready,
    input  logic                i_fifo_afull,
    output logic                o_piece_step,
    output logic                o_part_step,
    output logic                o_part_wrap,
    output logic                o_row_step,
    output logic                o_ker_row_step,
    output logic                o_issue,
    output conv_agu_pkg::ker_t  o_ker_col,
    output logic                o_first_part,
    output logic                o_last_part,
    output logic                o_job_done
);

    conv_agu_pkg::ker_state_e state;

    conv_agu_pkg::cnt_t  row_cnt;       // Output row
    conv_agu_pkg::cnt_t  opiece_cnt;    // Output piece
    conv_agu_pkg::part_t part_cnt;      // Column part
    conv_agu_pkg::cnt_t  ipiece_cnt;    // Input piece
    conv_agu_pkg::ker_t  krow_cnt;      // Kernel row
    conv_agu_pkg::ker_t  kcol_cnt;      // Kernel column

    logic row_end;
    logic opiece_end;
    logic part_end;
    logic ipiece_end;
    logic krow_end;
    logic kcol_end;
    logic col_en;
    logic col_wrap;
    logic job_end;
    logic busy;         // Set by start, cleared on the final issue
    logic done_pend;    // Final issue seen, its FIFO write still in flight

    // Last value of each loop
    assign row_end    = (row_cnt + 8'd1) == i_out_y_len;
    assign opiece_end = (opiece_cnt + 8'd1) == i_out_piece_num;
    assign part_end   = (conv_agu_pkg::cnt_t'(part_cnt) + 8'd1) == i_part_num;
    assign ipiece_end = (ipiece_cnt + 8'd1) == i_in_piece_num;
    assign krow_end   = (krow_cnt + 4'd1) == i_kernel;
    assign kcol_end   = (kcol_cnt + 4'd1) == i_kernel;

    // ------------------------------------------------------------------------
    // Issue and loop strobes, each outer loop steps on the inner wrap
    // ------------------------------------------------------------------------
    assign col_en         = (state == conv_agu_pkg::KER_COL_EN) && !i_fifo_afull;
    assign col_wrap       = col_en && kcol_end;
    assign o_piece_step   = col_wrap && krow_end;   // Last column of the piece
    assign o_ker_row_step = col_wrap && !krow_end;
    assign o_part_step    = o_piece_step && ipiece_end;
    assign o_part_wrap    = o_part_step && part_end;
    assign o_row_step     = o_part_wrap && opiece_end;
    assign job_end        = o_row_step && row_end;

    assign o_issue      = col_en;
    assign o_ker_col    = kcol_cnt;
    assign o_first_part = (part_cnt == '0);
    assign o_last_part  = part_end;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            row_cnt    <= '0;
            opiece_cnt <= '0;
            part_cnt   <= '0;
            ipiece_cnt <= '0;
            krow_cnt   <= '0;
            kcol_cnt   <= '0;
        end else if (i_start) begin
            row_cnt    <= '0;
            opiece_cnt <= '0;
            part_cnt   <= '0;
            ipiece_cnt <= '0;
            krow_cnt   <= '0;
            kcol_cnt   <= '0;
        end else begin   // All hold while the FIFO is almost full
            if (col_en)       kcol_cnt   <= kcol_end ? '0 : kcol_cnt + 4'd1;
            if (col_wrap)     krow_cnt   <= krow_end ? '0 : krow_cnt + 4'd1;
            if (o_piece_step) ipiece_cnt <= ipiece_end ? '0 : ipiece_cnt + 8'd1;
            if (o_part_step)  part_cnt   <= part_end ? '0 : part_cnt + 4'd1;
            if (o_part_wrap)  opiece_cnt <= opiece_end ? '0 : opiece_cnt + 8'd1;
            if (o_row_step)   row_cnt    <= row_end ? '0 : row_cnt + 8'd1;
        end
    end

    // Done trails the final issue so its entry is in the FIFO first
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            done_pend  <= 1'b0;
            o_job_done <= 1'b0;
        end else begin
            done_pend <= job_end;
            if (i_start) begin
                busy       <= 1'b1;
                o_job_done <= 1'b0;
            end else begin
                if (job_end)   busy       <= 1'b0;
                if (done_pend) o_job_done <= 1'b1;
            end
        end
    end

    // Kernel FSM
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= conv_agu_pkg::KER_IDLE;
        end else begin
            case (state)
                conv_agu_pkg::KER_IDLE:
                    if (i_addr_ready && busy) state <= conv_agu_pkg::KER_COL_EN;
                conv_agu_pkg::KER_COL_EN:
                    if (col_wrap) state <= conv_agu_pkg::KER_ROW_INC;
                conv_agu_pkg::KER_ROW_INC:   // Row counter already wrapped after the last row
                    state <= (krow_cnt == '0) ? conv_agu_pkg::KER_IDLE
                                              : conv_agu_pkg::KER_COL_EN;
                default:
                    state <= conv_agu_pkg::KER_IDLE;
            endcase
        end
    end

endmodule

//--- source/conv_agu_addr_pipe.sv
module conv_agu_addr_pipe (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_start,
    input  logic                  i_piece_step,
    input  logic                  i_part_step,
    input  logic                  i_part_wrap,
    input  logic                  i_row_step,
    input  logic                  i_ker_row_step,
    input  logic                  i_issue,
    input  conv_agu_pkg::ker_t    i_ker_col,
    input  logic                  i_first_part,
    input  logic                  i_last_part,
    input  conv_agu_pkg::addr_t   i_start_addr,
    input  conv_agu_pkg::cnt_t    i_in_x_len,
    input  conv_agu_pkg::addr_t   i_one_line_size,
    input  conv_agu_pkg::addr_t   i_stride_line_size,
    input  conv_agu_pkg::addr_t   i_part_stride,
    output logic                  o_addr_ready,
    output logic                  o_wr_en,
    output conv_agu_pkg::entry_t  o_wr_data
);

    // Strobe delay lines, bit n feeds stage n+1
    logic [conv_agu_pkg::PIPE_DEPTH-1:0] start_d;
    logic [conv_agu_pkg::PIPE_DEPTH-1:0] piece_d;
    logic [1:0]                          row_d;
    logic [1:0]                          part_d;
    logic                                wrap_d;

    conv_agu_pkg::addr_t line_addr;     // start + r * stride_line_size
    conv_agu_pkg::addr_t part_off;      // p * part_stride
    conv_agu_pkg::addr_t piece_addr;    // line + part + q * in_x_len
    conv_agu_pkg::addr_t krow_addr;     // piece + kr * one_line_size

    conv_agu_pkg::addr_t e_base;
    conv_agu_pkg::addr_t e_col;
    conv_agu_pkg::ker_t  e_kcol;
    logic                e_first;
    logic                e_last;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            start_d <= '0;
            piece_d <= '0;
            row_d   <= '0;
            part_d  <= '0;
            wrap_d  <= 1'b0;
            o_wr_en <= 1'b0;
        end else begin
            start_d <= {start_d[conv_agu_pkg::PIPE_DEPTH-2:0], i_start};
            piece_d <= {piece_d[conv_agu_pkg::PIPE_DEPTH-2:0], i_piece_step};
            row_d   <= {row_d[0], i_row_step};
            part_d  <= {part_d[0], i_part_step};
            wrap_d  <= i_part_wrap;
            o_wr_en <= i_issue;     // Write one cycle after issue
        end
    end

    // Kernel-row address is settled at the edge that ends this cycle
    assign o_addr_ready = start_d[conv_agu_pkg::PIPE_DEPTH-1]
                        | piece_d[conv_agu_pkg::PIPE_DEPTH-1];

    // ------------------------------------------------------------------------
    // Address stages
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        // Stage 1
        if (start_d[0])    line_addr <= i_start_addr;
        else if (row_d[0]) line_addr <= line_addr + i_stride_line_size;

        if (start_d[0] || wrap_d) part_off <= '0;
        else if (part_d[0])       part_off <= part_off + i_part_stride;

        // Stage 2, a new row or part restarts from input piece 0
        if (start_d[1] || row_d[1] || part_d[1])
            piece_addr <= line_addr + part_off;
        else if (piece_d[1])
            piece_addr <= piece_addr + conv_agu_pkg::addr_t'(i_in_x_len);

        // Stage 3
        if (start_d[2] || piece_d[2]) krow_addr <= piece_addr;
        else if (i_ker_row_step)      krow_addr <= krow_addr + i_one_line_size;
    end

    // Entry register
    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            e_base  <= krow_addr + conv_agu_pkg::addr_t'(i_ker_col);
            e_col   <= part_off + conv_agu_pkg::addr_t'(i_ker_col);
            e_kcol  <= i_ker_col;
            e_first <= i_first_part;
            e_last  <= i_last_part;
        end
    end

    assign o_wr_data = {e_first, e_last, e_kcol, e_col, e_base};

endmodule

//--- source/conv_agu_fifo.sv
module conv_agu_fifo (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wr_en,
    input  conv_agu_pkg::entry_t  i_wr_data,
    input  logic                  i_rd_en,
    output conv_agu_pkg::entry_t  o_rd_data,
    output logic                  o_empty,
    output logic                  o_afull
);

    conv_agu_pkg::entry_t    mem [conv_agu_pkg::FIFO_DEPTH];
    conv_agu_pkg::fifo_ptr_t wr_ptr;
    conv_agu_pkg::fifo_ptr_t rd_ptr;
    conv_agu_pkg::fifo_cnt_t count;
    logic                    rd_ok;

    assign rd_ok     = i_rd_en && !o_empty;     // Read on empty is ignored
    assign o_empty   = (count == '0);
    assign o_afull   = (count >= conv_agu_pkg::fifo_cnt_t'(conv_agu_pkg::FIFO_AFULL));
    assign o_rd_data = mem[rd_ptr];             // Show-ahead head entry

    always_ff @(posedge i_clk) begin
        if (i_wr_en) mem[wr_ptr] <= i_wr_data;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_en) wr_ptr <= wr_ptr + conv_agu_pkg::fifo_ptr_t'(1);
            if (rd_ok)   rd_ptr <= rd_ptr + conv_agu_pkg::fifo_ptr_t'(1);
            case ({i_wr_en, rd_ok})
                2'b10:   count <= count + conv_agu_pkg::fifo_cnt_t'(1);
                2'b01:   count <= count - conv_agu_pkg::fifo_cnt_t'(1);
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

//--- source/conv_agu_top.sv
module conv_agu_top (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start_req,
    input  conv_agu_pkg::addr_t     i_start_addr,
    input  conv_agu_pkg::cnt_t      i_in_piece_num,
    input  conv_agu_pkg::cnt_t      i_out_piece_num,
    input  conv_agu_pkg::cnt_t      i_out_y_len,
    input  conv_agu_pkg::cnt_t      i_part_num,
    input  conv_agu_pkg::cnt_t      i_in_x_len,
    input  conv_agu_pkg::stride_t   i_stride,
    input  conv_agu_pkg::ker_t      i_kernel,
    output logic                    o_start_ack,
    input  logic                    i_rd_en,
    output logic                    o_valid,
    output conv_agu_pkg::addr_t     o_base_addr,
    output conv_agu_pkg::addr_t     o_input_col,
    output conv_agu_pkg::ker_t      o_ker_col,
    output logic                    o_first_part,
    output logic                    o_last_part
);

    // Job configuration
    logic                start;
    conv_agu_pkg::cnt_t  in_piece_num;
    conv_agu_pkg::cnt_t  out_piece_num;
    conv_agu_pkg::cnt_t  out_y_len;
    conv_agu_pkg::cnt_t  part_num;
    conv_agu_pkg::cnt_t  in_x_len;
    conv_agu_pkg::ker_t  kernel;
    conv_agu_pkg::addr_t start_addr;
    conv_agu_pkg::addr_t one_line_size;
    conv_agu_pkg::addr_t stride_line_size;
    conv_agu_pkg::addr_t part_stride;

    // Loop strobes and issue
    logic               piece_step;
    logic               part_step;
    logic               part_wrap;
    logic               row_step;
    logic               ker_row_step;
    logic               issue;
    conv_agu_pkg::ker_t ker_col;
    logic               first_part;
    logic               last_part;
    logic               job_done;
    logic               addr_ready;

    // FIFO
    logic                 wr_en;
    conv_agu_pkg::entry_t wr_data;
    conv_agu_pkg::entry_t head;
    logic                 fifo_empty;
    logic                 fifo_afull;

    conv_agu_cfg u_cfg (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_start_req        (i_start_req),
        .i_start_addr       (i_start_addr),
        .i_in_piece_num     (i_in_piece_num),
        .i_out_piece_num    (i_out_piece_num),
        .i_out_y_len        (i_out_y_len),
        .i_part_num         (i_part_num),
        .i_in_x_len         (i_in_x_len),
        .i_stride           (i_stride),
        .i_kernel           (i_kernel),
        .i_job_done         (job_done),
        .i_fifo_empty       (fifo_empty),
        .o_start_ack        (o_start_ack),
        .o_start            (start),
        .o_in_piece_num     (in_piece_num),
        .o_out_piece_num    (out_piece_num),
        .o_out_y_len        (out_y_len),
        .o_part_num         (part_num),
        .o_in_x_len         (in_x_len),
        .o_kernel           (kernel),
        .o_start_addr       (start_addr),
        .o_one_line_size    (one_line_size),
        .o_stride_line_size (stride_line_size),
        .o_part_stride      (part_stride)
    );

    conv_agu_loop_ctrl u_loop_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (start),
        .i_in_piece_num  (in_piece_num),
        .i_out_piece_num (out_piece_num),
        .i_out_y_len     (out_y_len),
        .i_part_num      (part_num),
        .i_kernel        (kernel),
        .i_addr_ready    (addr_ready),
        .i_fifo_afull    (fifo_afull),
        .o_piece_step    (piece_step),
        .o_part_step     (part_step),
        .o_part_wrap     (part_wrap),
        .o_row_step      (row_step),
        .o_ker_row_step  (ker_row_step),
        .o_issue         (issue),
        .o_ker_col       (ker_col),
        .o_first_part    (first_part),
        .o_last_part     (last_part),
        .o_job_done      (job_done)
    );

    conv_agu_addr_pipe u_addr_pipe (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_start            (start),
        .i_piece_step       (piece_step),
        .i_part_step        (part_step),
        .i_part_wrap        (part_wrap),
        .i_row_step         (row_step),
        .i_ker_row_step     (ker_row_step),
        .i_issue            (issue),
        .i_ker_col          (ker_col),
        .i_first_part       (first_part),
        .i_last_part        (last_part),
        .i_start_addr       (start_addr),
        .i_in_x_len         (in_x_len),
        .i_one_line_size    (one_line_size),
        .i_stride_line_size (stride_line_size),
        .i_part_stride      (part_stride),
        .o_addr_ready       (addr_ready),
        .o_wr_en            (wr_en),
        .o_wr_data          (wr_data)
    );

    conv_agu_fifo u_fifo (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (wr_en),
        .i_wr_data (wr_data),
        .i_rd_en   (i_rd_en),
        .o_rd_data (head),
        .o_empty   (fifo_empty),
        .o_afull   (fifo_afull)
    );

    // Head entry fields
    assign o_valid      = !fifo_empty;
    assign o_first_part = head[29];
    assign o_last_part  = head[28];
    assign o_ker_col    = head[27:24];
    assign o_input_col  = head[23:12];
    assign o_base_addr  = head[11:0];

endmodule

//--- dv/conv_agu_tb.sv
module conv_agu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF   = 5;      // 10 ns period
    localparam int RST_CYCLES = 4;
    localparam int NUM_JOBS   = 3;
    localparam int HOLD_EXTRA = 8;      // Extra stalled cycles once the FIFO is almost full

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_start_req;
    conv_agu_pkg::addr_t   i_start_addr;
    conv_agu_pkg::cnt_t    i_in_piece_num;
    conv_agu_pkg::cnt_t    i_out_piece_num;
    conv_agu_pkg::cnt_t    i_out_y_len;
    conv_agu_pkg::cnt_t    i_part_num;
    conv_agu_pkg::cnt_t    i_in_x_len;
    conv_agu_pkg::stride_t i_stride;
    conv_agu_pkg::ker_t    i_kernel;
    logic                  i_rd_en;
    logic                  o_start_ack;
    logic                  o_valid;
    conv_agu_pkg::addr_t   o_base_addr;
    conv_agu_pkg::addr_t   o_input_col;
    conv_agu_pkg::ker_t    o_ker_col;
    logic                  o_first_part;
    logic                  o_last_part;

    // Job table with one column per job
    string job_name    [NUM_JOBS] = '{"k3_s1_hold", "k1_s2_wrap", "k2_s3_parts3"};
    int    job_addr    [NUM_JOBS] = '{'h100, 'hff0, 'h7a0};
    int    job_xlen    [NUM_JOBS] = '{10, 20, 50};
    int    job_ipieces [NUM_JOBS] = '{2, 3, 1};
    int    job_opieces [NUM_JOBS] = '{1, 2, 2};
    int    job_rows    [NUM_JOBS] = '{2, 3, 2};
    int    job_parts   [NUM_JOBS] = '{2, 1, 3};
    int    job_stride  [NUM_JOBS] = '{1, 2, 3};
    int    job_ker     [NUM_JOBS] = '{3, 1, 2};

    logic [31:0] lfsr;          // Read stall pattern
    logic [29:0] exp_q[$];      // {first, last, kcol, col, base}
    int          errors = 0;
    int          checks = 0;
    int          popped;        // Entries popped in the current job
    int          cycles = 0;
    int          cycle_limit;
    string       test_name;

    conv_agu_top u_dut (.*);

    always #CLK_HALF i_clk = ~i_clk;

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    function automatic int job_entries(input int j);
        return job_rows[j] * job_opieces[j] * job_parts[j] * job_ipieces[j]
               * job_ker[j] * job_ker[j];
    endfunction

    task automatic report_mismatch(input string field, input int exp_v, input int act_v);
        $display("ERR %s %s exp=0x%0h act=0x%0h", test_name, field, exp_v, act_v);
        errors++;
    endtask

    // ------------------------------------------------------------------------
    // Reference model in loop order from the outermost loop
    // ------------------------------------------------------------------------
    task automatic build_model(input int j);
        int ols;
        int sll;
        int pstr;
        int base;
        int col;
        int r;
        int op;
        int p;
        int q;
        int kr;
        int kc;
        ols  = (job_xlen[j] * job_ipieces[j]) & 'hfff;    // One input line
        sll  = (ols * job_stride[j]) & 'hfff;
        pstr = conv_agu_pkg::PE_COLS * job_stride[j];
        exp_q.delete();
        for (r = 0; r < job_rows[j]; r++)
            for (op = 0; op < job_opieces[j]; op++)      // No effect on the address
                for (p = 0; p < job_parts[j]; p++)
                    for (q = 0; q < job_ipieces[j]; q++)
                        for (kr = 0; kr < job_ker[j]; kr++)
                            for (kc = 0; kc < job_ker[j]; kc++) begin
                                base = (job_addr[j] + r * sll + q * job_xlen[j]
                                        + p * pstr + kr * ols + kc) & 'hfff;
                                col  = (p * pstr + kc) & 'hfff;
                                exp_q.push_back({p == 0, p == job_parts[j] - 1,
                                                 4'(kc), 12'(col), 12'(base)});
                            end
    endtask

    // Head entry against the model before the pop at the next rising edge
    task automatic check_head();
        logic [29:0] e;
        popped++;
        assert (exp_q.size() > 0) else begin
            $display("Entry popped beyond the expected stream in %s", test_name);
            errors++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (o_base_addr == e[11:0]) else report_mismatch("base", e[11:0], o_base_addr);
            assert (o_input_col == e[23:12]) else report_mismatch("col", e[23:12], o_input_col);
            assert (o_ker_col == e[27:24]) else report_mismatch("kcol", e[27:24], o_ker_col);
            assert (o_first_part == e[29]) else report_mismatch("first", e[29], o_first_part);
            assert (o_last_part == e[28]) else report_mismatch("last", e[28], o_last_part);
        end
    endtask

    // Drive i_rd_en on a falling edge and check what gets popped
    task automatic step_cycle(input logic hold);
        logic b0;
        logic b1;
        @(negedge i_clk);
        if (hold) begin
            i_rd_en = 1'b0;
        end else begin
            b0      = lfsr[0];
            lfsr    = lfsr_next(lfsr);
            b1      = lfsr[0];
            lfsr    = lfsr_next(lfsr);
            i_rd_en = b0 | b1;      // Reads three cycles in four
        end
        assert (!o_start_ack || exp_q.size() == 0) else begin
            $display("o_start_ack high with %0d entries still due in %s",
                     exp_q.size(), test_name);
            errors++;
        end
        if (i_rd_en && o_valid) check_head();
    endtask

    // ------------------------------------------------------------------------
    // Job with the four-phase handshake
    // ------------------------------------------------------------------------
    task automatic run_job(input int j);
        test_name = job_name[j];
        popped    = 0;
        build_model(j);
        @(negedge i_clk);
        i_start_addr    = 12'(job_addr[j]);
        i_in_x_len      = 8'(job_xlen[j]);
        i_in_piece_num  = 8'(job_ipieces[j]);
        i_out_piece_num = 8'(job_opieces[j]);
        i_out_y_len     = 8'(job_rows[j]);
        i_part_num      = 8'(job_parts[j]);
        i_stride        = 2'(job_stride[j]);
        i_kernel        = 4'(job_ker[j]);
        i_start_req     = 1'b1;
        if (j == 0) begin   // Let the FIFO fill and stall the loops
            while (!u_dut.fifo_afull) step_cycle(1'b1);
            repeat (HOLD_EXTRA) step_cycle(1'b1);
        end
        while (!o_start_ack) step_cycle(1'b0);
        i_rd_en = 1'b0;
        assert (popped == job_entries(j)) else report_mismatch("count", job_entries(j), popped);
        assert (!o_valid) else report_mismatch("valid_at_ack", 0, o_valid);
        repeat (2) begin    // Ack holds while req is high
            @(negedge i_clk);
            assert (o_start_ack) else report_mismatch("ack_hold", 1, o_start_ack);
        end
        i_start_req = 1'b0;
        @(negedge i_clk);
        assert (!o_start_ack) else report_mismatch("ack_fall", 0, o_start_ack);
    endtask

    // Run limit from the total stream length
    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Checks: %0d entries, %0d errors", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int total;
        total = 0;
        for (int j = 0; j < NUM_JOBS; j++) total += job_entries(j);
        cycle_limit = 20 * total + 200 * NUM_JOBS;
        lfsr            = 32'd80440;
        i_clk           = 1'b0;
        i_rst_n         = 1'b0;
        i_start_req     = 1'b0;
        i_start_addr    = '0;
        i_in_piece_num  = '0;
        i_out_piece_num = '0;
        i_out_y_len     = '0;
        i_part_num      = '0;
        i_in_x_len      = '0;
        i_stride        = '0;
        i_kernel        = '0;
        i_rd_en         = 1'b0;
        test_name       = "reset";
        for (int c = 0; c < RST_CYCLES + 2; c++) begin
            @(negedge i_clk);
            assert (!o_valid) else report_mismatch("valid", 0, o_valid);
            assert (!o_start_ack) else report_mismatch("ack", 0, o_start_ack);
            if (c == RST_CYCLES - 1) i_rst_n = 1'b1;
        end
        for (int j = 0; j < NUM_JOBS; j++) run_job(j);
        $display("Checks: %0d entries, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- conv_agu.f
source/conv_agu_pkg.sv
source/conv_agu_cfg.sv
source/conv_agu_loop_ctrl.sv
source/conv_agu_addr_pipe.sv
source/conv_agu_fifo.sv
source/conv_agu_top.sv
dv/conv_agu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conv_agu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
        --top-module conv_agu_tb -Mdir obj_dir -f conv_agu.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vconv_agu_tb > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
